// File: rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // Master side of the peripheral bus, held while req is high
  typedef struct packed {
    logic [15:0] addr;
    logic [15:0] wdata;
    logic        write;
  } bus_req_t;

  typedef struct packed {
    logic [15:0] rdata;
    logic        fault;
  } bus_rsp_t;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_SWITCH,
    REG_ENCODER,
    REG_UART,
    REG_DISPLAY
  } soc_region_e;

  // Word addresses
  localparam logic [15:0] SWITCH_BASE  = 16'h8000;
  localparam logic [15:0] ENCODER_BASE = 16'h8010;
  localparam logic [15:0] UART_BASE    = 16'h8020;
  localparam logic [15:0] DISPLAY_BASE = 16'h8030;

  typedef enum logic [2:0] {
    RGB_RED   = 3'b100,
    RGB_GREEN = 3'b010,
    RGB_BLUE  = 3'b001
  } rgb_color_e;

  // Shared write/strobe bus to every peripheral
  typedef struct packed {
    logic [1:0]  addr;
    logic [15:0] wdata;
    logic        write;
    logic        strobe;
  } periph_wr_t;

endpackage

`default_nettype wire

// File: rtl/mem_select.sv
`default_nettype none

module mem_select
  import soc_pkg::*;
(
  input  wire          clock_50,
  input  wire          rst_n,
  input  wire bus_req_t bus_req,
  input  wire          req,
  output logic         ack,
  output bus_rsp_t     bus_rsp,
  input  wire  [7:0]   sw,
  output periph_wr_t   periph,
  output logic         sel_encoder,
  output logic         sel_uart,
  output logic         sel_display,
  input  wire  [15:0]  encoder_rdata,
  input  wire  [15:0]  uart_rdata,
  output soc_region_e  region
);

  typedef enum logic [1:0] {IDLE, STROBE, RESP, WAIT_LOW} state_e;

  state_e      state;
  soc_region_e region_d;
  logic        sel_switch;
  logic        strobe;
  logic [15:0] rdata_mux;

  always_comb begin
    if (bus_req.addr == SWITCH_BASE)
      region_d = REG_SWITCH;
    else if (bus_req.addr[15:2] == ENCODER_BASE[15:2])
      region_d = REG_ENCODER;
    else if (bus_req.addr[15:2] == UART_BASE[15:2])
      region_d = REG_UART;
    else if (bus_req.addr == DISPLAY_BASE)
      region_d = REG_DISPLAY;
    else
      region_d = REG_NONE;
  end

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      region <= REG_NONE;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state  <= STROBE;
            region <= region_d;
          end
        end
        STROBE: state <= RESP;
        RESP: state <= req ? WAIT_LOW : IDLE;
        WAIT_LOW: begin
          if (!req)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign strobe      = (state == STROBE);
  assign sel_switch  = strobe && (region == REG_SWITCH);
  assign sel_encoder = strobe && (region == REG_ENCODER);
  assign sel_uart    = strobe && (region == REG_UART);
  assign sel_display = strobe && (region == REG_DISPLAY);
  assign ack         = (state == RESP) || (state == WAIT_LOW);

  // bus_req is stable for the whole access
  assign periph = '{addr: bus_req.addr[1:0], wdata: bus_req.wdata,
                    write: bus_req.write, strobe: strobe};

  // Display returns nothing, so it reads back as zero
  assign rdata_mux = (sel_switch  ? {8'h00, sw}   : 16'h0000) |
                     (sel_encoder ? encoder_rdata : 16'h0000) |
                     (sel_uart    ? uart_rdata    : 16'h0000);

  always_ff @(posedge clock_50) begin
    if (strobe) begin
      bus_rsp.rdata <= rdata_mux;
      bus_rsp.fault <= (region == REG_NONE);
    end
  end

  assert property (@(posedge clock_50) disable iff (!rst_n)
    $fell(ack) |-> !$past(req))
    else $error("ack dropped while req was still high");

  assert property (@(posedge clock_50) disable iff (!rst_n)
    $onehot0({sel_switch, sel_encoder, sel_uart, sel_display}))
    else $error("more than one peripheral selected");

endmodule

`default_nettype wire

// File: rtl/uart.sv
`default_nettype none

module uart
  import soc_pkg::*;
#(
  parameter int BAUD_DIV = 434
) (
  input  wire             clock_50,
  input  wire             rst_n,
  input  wire periph_wr_t periph,
  input  wire             sel,
  output logic [15:0]     rdata,
  input  wire             rx,
  output logic            tx
);

  localparam int CW = $clog2(BAUD_DIV + 1);

  logic          acc;
  logic          wr_data;
  logic          rd_data;
  logic          wr_status;
  logic          tx_busy;
  logic          tx_load;
  logic          tx_tick;
  logic [9:0]    tx_shift;
  logic [CW-1:0] tx_cnt;
  logic [3:0]    tx_bitn;
  logic          tx_dropped;
  logic [1:0]    rx_sync;
  logic          rx_active;
  logic          rx_tick;
  logic          rx_done;
  logic [CW-1:0] rx_cnt;
  logic [3:0]    rx_bitn;
  logic [7:0]    rx_shift;
  logic [7:0]    rx_data;
  logic          rx_valid;
  logic          rx_overrun;

  assign acc       = sel && periph.strobe;
  assign wr_data   = acc && periph.write && (periph.addr == 2'd0);
  assign rd_data   = acc && !periph.write && (periph.addr == 2'd0);
  assign wr_status = acc && periph.write && (periph.addr == 2'd1);

  // Transmit frame is start bit, 8 data bits LSB first and stop bit
  assign tx_load = wr_data && !tx_busy;
  assign tx_tick = tx_busy && (tx_cnt == CW'(BAUD_DIV - 1));

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      tx_cnt  <= '0;
      tx_bitn <= '0;
    end else if (tx_load) begin
      tx_busy <= 1'b1;
      tx_cnt  <= '0;
      tx_bitn <= '0;
    end else if (tx_tick) begin
      tx_cnt  <= '0;
      tx_bitn <= tx_bitn + 4'd1;
      if (tx_bitn == 4'd9)
        tx_busy <= 1'b0;
    end else if (tx_busy) begin
      tx_cnt <= tx_cnt + CW'(1);
    end
  end

  always_ff @(posedge clock_50) begin
    if (tx_load)
      tx_shift <= {1'b1, periph.wdata[7:0], 1'b0};
    else if (tx_tick)
      tx_shift <= {1'b1, tx_shift[9:1]};
  end

  assign tx = tx_busy ? tx_shift[0] : 1'b1;

  // Receiver samples mid-bit from half a bit after the falling edge
  assign rx_tick = rx_active && (rx_cnt == '0);
  assign rx_done = rx_tick && (rx_bitn == 4'd9) && rx_sync[1];

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync   <= 2'b11;
      rx_active <= 1'b0;
      rx_cnt    <= '0;
      rx_bitn   <= '0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      if (!rx_active) begin
        if (!rx_sync[1]) begin
          rx_active <= 1'b1;
          rx_cnt    <= CW'(BAUD_DIV / 2);
          rx_bitn   <= '0;
        end
      end else if (rx_tick) begin
        rx_cnt  <= CW'(BAUD_DIV - 1);
        rx_bitn <= rx_bitn + 4'd1;
        // False start or stop bit reached
        if ((rx_bitn == 4'd0 && rx_sync[1]) || rx_bitn == 4'd9)
          rx_active <= 1'b0;
      end else begin
        rx_cnt <= rx_cnt - CW'(1);
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (rx_tick && rx_bitn != 4'd0 && rx_bitn != 4'd9)
      rx_shift <= {rx_sync[1], rx_shift[7:1]};
    if (rx_done)
      rx_data <= rx_shift;
  end

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
      tx_dropped <= 1'b0;
    end else begin
      if (wr_status) begin
        rx_overrun <= 1'b0;
        tx_dropped <= 1'b0;
      end
      if (wr_data && tx_busy)
        tx_dropped <= 1'b1;
      if (rx_done) begin
        rx_valid <= 1'b1;
        if (rx_valid && !rd_data)
          rx_overrun <= 1'b1;
      end else if (rd_data) begin
        rx_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    case (periph.addr)
      2'd0:    rdata = {8'h00, rx_data};
      2'd1:    rdata = {12'h000, tx_dropped, rx_overrun, tx_busy, rx_valid};
      default: rdata = 16'h0000;
    endcase
  end

  assert property (@(posedge clock_50) disable iff (!rst_n)
    (tx_busy && !tx_tick) |=> $stable(tx_shift))
    else $error("transmit shift register loaded while busy");

endmodule

`default_nettype wire

// File: rtl/rgb_enc.sv
`default_nettype none

module rgb_enc
  import soc_pkg::*;
(
  input  wire             clock_50,
  input  wire             rst_n,
  input  wire periph_wr_t periph,
  input  wire             sel,
  output logic [15:0]     rdata,
  input  wire  [1:0]      quad,
  input  wire             button,
  output rgb_color_e      rgb
);

  logic [1:0] quad_s1;
  logic [1:0] quad_s2;
  logic [1:0] quad_prev;
  logic [2:0] btn_sync;
  logic [4:0] pos;
  logic       pressed;
  logic       step_up;
  logic       step_dn;
  logic       wr_pos;
  logic       wr_btn;

  assign wr_pos = sel && periph.strobe && periph.write && (periph.addr == 2'd0);
  assign wr_btn = sel && periph.strobe && periph.write && (periph.addr == 2'd1);

  // Gray order 00 01 11 10 counts up
  always_comb begin
    step_up = 1'b0;
    step_dn = 1'b0;
    case ({quad_prev, quad_s2})
      4'b0001, 4'b0111, 4'b1110, 4'b1000: step_up = 1'b1;
      4'b0010, 4'b1011, 4'b1101, 4'b0100: step_dn = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      quad_s1   <= 2'b00;
      quad_s2   <= 2'b00;
      quad_prev <= 2'b00;
      btn_sync  <= 3'b000;
      pos       <= 5'd0;
      pressed   <= 1'b0;
    end else begin
      quad_s1   <= quad;
      quad_s2   <= quad_s1;
      quad_prev <= quad_s2;
      btn_sync  <= {btn_sync[1:0], button};
      if (wr_pos)
        pos <= 5'(periph.wdata % 16'd24);
      else if (step_up)
        pos <= (pos == 5'd23) ? 5'd0 : pos + 5'd1;
      else if (step_dn)
        pos <= (pos == 5'd0) ? 5'd23 : pos - 5'd1;
      // A new press wins over a clear
      if (btn_sync[1] && !btn_sync[2])
        pressed <= 1'b1;
      else if (wr_btn)
        pressed <= 1'b0;
    end
  end

  assign rdata = (periph.addr == 2'd0) ? {11'd0, pos} :
                 (periph.addr == 2'd1) ? {15'd0, pressed} : 16'h0000;

  always_comb begin
    if (pos < 5'd8)
      rgb = RGB_RED;
    else if (pos < 5'd16)
      rgb = RGB_GREEN;
    else
      rgb = RGB_BLUE;
  end

  assert property (@(posedge clock_50) disable iff (!rst_n) pos <= 5'd23)
    else $error("encoder position out of range");

endmodule

`default_nettype wire

// File: rtl/status_display.sv
`default_nettype none

module status_display
  import soc_pkg::*;
(
  input  wire             clock_50,
  input  wire             rst_n,
  input  wire periph_wr_t periph,
  input  wire             sel,
  input  wire  [15:0]     bus_addr,
  input  wire soc_region_e region,
  input  wire             strobe_any,
  output logic [6:0]      hex0,
  output logic [6:0]      hex1,
  output logic [6:0]      hex2,
  output logic [6:0]      hex3,
  output logic [6:0]      hex4,
  output logic [6:0]      hex5,
  output logic [6:0]      hex6,
  output logic [6:0]      hex7,
  output logic [8:0]      ledg
);

  logic [15:0] addr_q;
  logic [15:0] value;

  // Segments gfedcba, low is lit
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= 16'h0000;
      value  <= 16'h0000;
      ledg   <= 9'd0;
    end else begin
      if (strobe_any) begin
        addr_q <= bus_addr;
        ledg   <= {region == REG_NONE, 4'b0000, region == REG_SWITCH,
                   region == REG_ENCODER, region == REG_UART, region == REG_DISPLAY};
      end
      if (sel && periph.strobe && periph.write && periph.addr == 2'd0)
        value <= periph.wdata;
    end
  end

  assign hex0 = hex_to_seg(value[3:0]);
  assign hex1 = hex_to_seg(value[7:4]);
  assign hex2 = hex_to_seg(value[11:8]);
  assign hex3 = hex_to_seg(value[15:12]);
  assign hex4 = hex_to_seg(addr_q[3:0]);
  assign hex5 = hex_to_seg(addr_q[7:4]);
  assign hex6 = hex_to_seg(addr_q[11:8]);
  assign hex7 = hex_to_seg(addr_q[15:12]);

endmodule

`default_nettype wire

// File: rtl/soc.sv
`default_nettype none

module soc
  import soc_pkg::*;
#(
  parameter int BAUD_DIV = 434
) (
  input  wire           clock_50,
  input  wire           rst_n,
  input  wire bus_req_t bus_req,
  input  wire           req,
  output logic          ack,
  output bus_rsp_t      bus_rsp,
  input  wire  [7:0]    sw,
  input  wire  [1:0]    quad,
  input  wire           pb,
  input  wire           serial_rx,
  output logic          serial_tx,
  output rgb_color_e    rgb,
  output logic [6:0]    hex0,
  output logic [6:0]    hex1,
  output logic [6:0]    hex2,
  output logic [6:0]    hex3,
  output logic [6:0]    hex4,
  output logic [6:0]    hex5,
  output logic [6:0]    hex6,
  output logic [6:0]    hex7,
  output logic [8:0]    ledg
);

  logic [1:0]  rst_sync;
  logic        sys_rst_n;
  periph_wr_t  periph;
  logic        sel_encoder;
  logic        sel_uart;
  logic        sel_display;
  logic [15:0] encoder_rdata;
  logic [15:0] uart_rdata;
  soc_region_e region;

  // Asserts at once, releases two clocks later
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n)
      rst_sync <= 2'b00;
    else
      rst_sync <= {rst_sync[0], 1'b1};
  end

  assign sys_rst_n = rst_sync[1];

  mem_select u_mem_select (
    .clock_50(clock_50), .rst_n(sys_rst_n),
    .bus_req(bus_req), .req(req), .ack(ack), .bus_rsp(bus_rsp),
    .sw(sw), .periph(periph),
    .sel_encoder(sel_encoder), .sel_uart(sel_uart), .sel_display(sel_display),
    .encoder_rdata(encoder_rdata), .uart_rdata(uart_rdata), .region(region)
  );

  uart #(.BAUD_DIV(BAUD_DIV)) u_uart (
    .clock_50(clock_50), .rst_n(sys_rst_n), .periph(periph), .sel(sel_uart),
    .rdata(uart_rdata), .rx(serial_rx), .tx(serial_tx)
  );

  rgb_enc u_rgb_enc (
    .clock_50(clock_50), .rst_n(sys_rst_n), .periph(periph), .sel(sel_encoder),
    .rdata(encoder_rdata), .quad(quad), .button(pb), .rgb(rgb)
  );

  status_display u_status_display (
    .clock_50(clock_50), .rst_n(sys_rst_n), .periph(periph), .sel(sel_display),
    .bus_addr(bus_req.addr), .region(region), .strobe_any(periph.strobe),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
    .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7), .ledg(ledg)
  );

endmodule

`default_nettype wire

// File: tb/tb_soc.sv
`default_nettype none

module tb_soc
  import soc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ACK_TIMEOUT = 16;
  localparam int POLL_LIMIT  = 200;

  logic        clock_50 = 1'b0;
  logic        rst_n;
  bus_req_t    bus_req;
  logic        req;
  logic        ack;
  bus_rsp_t    bus_rsp;
  logic [7:0]  sw;
  logic [1:0]  quad;
  logic        pb;
  wire         serial_line;
  rgb_color_e  rgb;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;
  logic [6:0]  hex6;
  logic [6:0]  hex7;
  logic [8:0]  ledg;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          quad_phase = 0;
  logic [31:0] lcg_state = 32'hc2d5_f631;

  soc #(.BAUD_DIV(8)) u_soc (
    .clock_50(clock_50), .rst_n(rst_n),
    .bus_req(bus_req), .req(req), .ack(ack), .bus_rsp(bus_rsp),
    .sw(sw), .quad(quad), .pb(pb),
    .serial_rx(serial_line), .serial_tx(serial_line), .rgb(rgb),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
    .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7), .ledg(ledg)
  );

  always #20 clock_50 = ~clock_50;

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  // Active-low pins built from the lit segments gfedcba
  function automatic logic [6:0] seg_ref(input logic [3:0] digit);
    logic [6:0] lit;
    case (digit)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  function automatic logic [1:0] gray_code(input int phase);
    case (phase)
      0: return 2'b00;
      1: return 2'b01;
      2: return 2'b11;
      default: return 2'b10;
    endcase
  endfunction

  task automatic check_rsp(input bus_rsp_t got, input logic [15:0] exp_data,
                           input logic exp_fault, input string what);
    checks++;
    if (got.rdata !== exp_data || got.fault !== exp_fault) begin
      $display("ERR %0t: %s read %h fault %b, expected %h fault %b", $time, what,
               got.rdata, got.fault, exp_data, exp_fault);
      errors++;
    end
  endtask

  task automatic check_color(input rgb_color_e got, input rgb_color_e exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s colour %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_seg(input logic [6:0] got, input logic [3:0] digit, input string what);
    checks++;
    if (got !== seg_ref(digit)) begin
      $display("ERR %0t: %s segments %b, expected digit %h", $time, what, got, digit);
      errors++;
    end
  endtask

  task automatic check_ledg(input logic [8:0] got, input logic [8:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s ledg %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_edges(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      $display("ERR %0t: %s took %0d edges, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // Four-phase exchange that counts edges after the driving edge
  task automatic bus_access(input logic [15:0] addr, input logic [15:0] wdata,
                            input logic write, output bus_rsp_t rsp,
                            output int rise_n, output int fall_n);
    @(posedge clock_50);
    bus_req <= '{addr: addr, wdata: wdata, write: write};
    req     <= 1'b1;
    rise_n = 0;
    do begin
      @(posedge clock_50);
      rise_n++;
      @(negedge clock_50);
    end while (!ack && rise_n < ACK_TIMEOUT);
    if (!ack) begin
      $display("Handshake failure: ack never rose for address %h", addr);
      errors++;
    end
    rsp = bus_rsp;
    @(posedge clock_50);
    req <= 1'b0;
    fall_n = 0;
    do begin
      @(posedge clock_50);
      fall_n++;
      @(negedge clock_50);
    end while (ack && fall_n < ACK_TIMEOUT);
    if (ack) begin
      $display("Handshake failure: ack never fell for address %h", addr);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [15:0] wdata);
    bus_rsp_t rsp;
    int       rise_n;
    int       fall_n;
    bus_access(addr, wdata, 1'b1, rsp, rise_n, fall_n);
  endtask

  task automatic bus_read(input logic [15:0] addr, output bus_rsp_t rsp);
    int rise_n;
    int fall_n;
    bus_access(addr, 16'h0000, 1'b0, rsp, rise_n, fall_n);
  endtask

  task automatic poll_uart_status(input logic [3:0] mask, input logic [3:0] value,
                                  output bus_rsp_t rsp);
    int polls;
    polls = 0;
    do begin
      bus_read(UART_BASE + 16'd1, rsp);
      polls++;
    end while ((rsp.rdata[3:0] & mask) != value && polls < POLL_LIMIT);
    if ((rsp.rdata[3:0] & mask) != value) begin
      $display("UART status never reached %b under mask %b", value, mask);
      errors++;
    end
  endtask

  task automatic quad_step(input logic up);
    quad_phase = up ? (quad_phase + 1) % 4 : (quad_phase + 3) % 4;
    @(posedge clock_50);
    quad <= gray_code(quad_phase);
    repeat (4) @(posedge clock_50);
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    if (errors == err_start)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - err_start);
  endtask

  task automatic handshake_and_decode();
    int         err_start;
    bus_rsp_t   rsp;
    int         rise_n;
    int         fall_n;
    logic [7:0] b;
    err_start = errors;
    check_color(rgb, RGB_RED, "rgb after reset");
    check_seg(hex0, 4'h0, "hex0 after reset");
    check_seg(hex7, 4'h0, "hex7 after reset");
    check_ledg(ledg, 9'd0, "after reset");
    b = rand_byte();
    @(posedge clock_50);
    sw <= b;
    bus_access(SWITCH_BASE, 16'h0000, 1'b0, rsp, rise_n, fall_n);
    check_rsp(rsp, {8'h00, b}, 1'b0, "switch read");
    check_edges(rise_n, 2, "req to ack");
    check_edges(fall_n, 1, "req low to ack low");
    bus_read(16'h1234, rsp);
    check_rsp(rsp, 16'h0000, 1'b1, "unmapped read");
    report_test("handshake and decode", err_start);
  endtask

  task automatic uart_loopback();
    int         err_start;
    bus_rsp_t   rsp;
    logic [7:0] b;
    err_start = errors;
    for (int i = 0; i < 8; i++) begin
      b = rand_byte();
      bus_write(UART_BASE, {8'h00, b});
      poll_uart_status(4'b0001, 4'b0001, rsp);
      bus_read(UART_BASE, rsp);
      check_rsp(rsp, {8'h00, b}, 1'b0, "loopback byte");
    end
    poll_uart_status(4'b0010, 4'b0000, rsp);
    check_rsp(rsp, 16'h0000, 1'b0, "status after loopback");
    // Second write lands while the first byte is still shifting out
    b = rand_byte();
    bus_write(UART_BASE, {8'h00, b});
    bus_write(UART_BASE, 16'h00A5);
    bus_read(UART_BASE + 16'd1, rsp);
    check_rsp(rsp, 16'h000A, 1'b0, "status after dropped write");
    poll_uart_status(4'b0001, 4'b0001, rsp);
    bus_read(UART_BASE, rsp);
    check_rsp(rsp, {8'h00, b}, 1'b0, "byte ahead of dropped write");
    bus_write(UART_BASE + 16'd1, 16'h0000);
    poll_uart_status(4'b0010, 4'b0000, rsp);
    check_rsp(rsp, 16'h0000, 1'b0, "status after clear");
    report_test("uart loopback", err_start);
  endtask

  task automatic uart_overrun();
    int         err_start;
    bus_rsp_t   rsp;
    logic [7:0] first;
    logic [7:0] second;
    err_start = errors;
    first = rand_byte();
    second = rand_byte();
    bus_write(UART_BASE, {8'h00, first});
    poll_uart_status(4'b0010, 4'b0000, rsp);
    bus_write(UART_BASE, {8'h00, second});
    poll_uart_status(4'b0100, 4'b0100, rsp);
    poll_uart_status(4'b0010, 4'b0000, rsp);
    check_rsp(rsp, 16'h0005, 1'b0, "overrun status");
    bus_read(UART_BASE, rsp);
    check_rsp(rsp, {8'h00, second}, 1'b0, "data after overrun");
    bus_write(UART_BASE + 16'd1, 16'h0000);
    bus_read(UART_BASE + 16'd1, rsp);
    check_rsp(rsp, 16'h0000, 1'b0, "status after overrun clear");
    report_test("uart overrun", err_start);
  endtask

  task automatic encoder_steps();
    int       err_start;
    bus_rsp_t rsp;
    err_start = errors;
    bus_write(ENCODER_BASE, 16'd20);
    repeat (10) quad_step(1'b1);
    bus_read(ENCODER_BASE, rsp);
    check_rsp(rsp, 16'((20 + 10) % 24), 1'b0, "position after up-steps");
    check_color(rgb, RGB_RED, "rgb after up-steps");
    bus_write(ENCODER_BASE, 16'd0);
    quad_step(1'b0);
    bus_read(ENCODER_BASE, rsp);
    check_rsp(rsp, 16'd23, 1'b0, "position after wrap down");
    check_color(rgb, RGB_BLUE, "rgb after wrap down");
    report_test("encoder", err_start);
  endtask

  task automatic button_latch();
    int       err_start;
    bus_rsp_t rsp;
    err_start = errors;
    @(posedge clock_50);
    pb <= 1'b1;
    repeat (6) @(posedge clock_50);
    pb <= 1'b0;
    repeat (6) @(posedge clock_50);
    bus_read(ENCODER_BASE + 16'd1, rsp);
    check_rsp(rsp, 16'h0001, 1'b0, "button flag after press");
    bus_write(ENCODER_BASE + 16'd1, 16'h0000);
    bus_read(ENCODER_BASE + 16'd1, rsp);
    check_rsp(rsp, 16'h0000, 1'b0, "button flag after clear");
    report_test("button", err_start);
  endtask

  task automatic display_status();
    int       err_start;
    bus_rsp_t rsp;
    err_start = errors;
    bus_write(DISPLAY_BASE, 16'hBEEF);
    check_seg(hex3, 4'hB, "hex3");
    check_seg(hex2, 4'hE, "hex2");
    check_seg(hex1, 4'hE, "hex1");
    check_seg(hex0, 4'hF, "hex0");
    check_seg(hex7, 4'h8, "hex7");
    check_seg(hex6, 4'h0, "hex6");
    check_seg(hex5, 4'h3, "hex5");
    check_seg(hex4, 4'h0, "hex4");
    check_ledg(ledg, 9'b0_0000_0001, "after display write");
    bus_read(16'h1234, rsp);
    check_ledg(ledg, 9'b1_0000_0000, "after unmapped read");
    report_test("display", err_start);
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    bus_req = '0;
    sw = 8'h00;
    quad = 2'b00;
    pb = 1'b0;
    repeat (5) @(posedge clock_50);
    rst_n <= 1'b1;
    repeat (4) @(posedge clock_50);

    handshake_and_decode();
    uart_loopback();
    uart_overrun();
    encoder_steps();
    button_latch();
    display_status();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
rtl/soc_pkg.sv
rtl/mem_select.sv
rtl/uart.sv
rtl/rgb_enc.sv
rtl/status_display.sv
rtl/soc.sv
tb/tb_soc.sv

// File: Bender.yml
package:
  name: soc

sources:
  - rtl/soc_pkg.sv
  - rtl/mem_select.sv
  - rtl/uart.sv
  - rtl/rgb_enc.sv
  - rtl/status_display.sv
  - rtl/soc.sv
  - target: simulation
    files:
      - tb/tb_soc.sv
